/* pcw_sysctl.f */
+incdir+hw
+incdir+test
hw/pcw_pkg.sv
hw/pcw_io_regs.sv
hw/pcw_bank_map.sv
hw/pcw_int_ctrl.sv
hw/mono_palette.sv
hw/pcw_sysctl.sv
test/tb_pcw_sysctl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f pcw_sysctl.f --top-module tb_pcw_sysctl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pcw_sysctl)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if grep -q -F "Simulation completed successfully" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* test/tb_pcw_props.svh */
// Status byte as the CPU sees it on F4 and F8
function automatic logic [7:0] status_expected(input logic [7:0] adr);
    if (adr == `PORT_LOCK || adr == `PORT_SYSCTL)
        return {1'b0, vblank, m_fdc_latch, ~ntsc, m_misses};
    return 8'hFF;
endfunction

// Bank translation, PCW block or CPC read/write block
function automatic logic [17:0] map_expected(input logic [15:0] addr, input logic rd);
    int         slot;
    logic [7:0] pg;
    logic [2:0] blk;
    slot = int'(addr[15:14]);
    pg   = page_val[slot];
    if (pg[7])
        return {pg[3:0], addr[13:0]};
    // Lock bits sit above the four low bits, one per slot
    if (rd && !lock_val[4 + slot])
        blk = pg[6:4];
    else
        blk = pg[2:0];
    return {1'b0, blk, addr[13:0]};
endfunction

// Black, bright or normal colour of the chosen display
function automatic logic [17:0] palette_expected(input disp_color_e col, input logic [3:0] v);
    logic [17:0] norm_c;
    logic [17:0] bright_c;
    case (col)
        DISP_WHITE:
        begin
            norm_c   = `RGB_WHITE_NORM;
            bright_c = `RGB_WHITE_BRIGHT;
        end
        DISP_GREEN:
        begin
            norm_c   = `RGB_GREEN_NORM;
            bright_c = `RGB_GREEN_BRIGHT;
        end
        DISP_AMBER:
        begin
            norm_c   = `RGB_AMBER_NORM;
            bright_c = `RGB_AMBER_BRIGHT;
        end
        default: return `RGB_WHITE_NORM;
    endcase
    if (v == 4'd0)
        return 18'd0;
    if (v == 4'd8)
        return bright_c;
    return norm_c;
endfunction

// Single ack pulse per bus cycle
ack_single: assert property (@(posedge clk_sys) disable iff (reset) wb_ack |=> !wb_ack)
    else log_failure("wb_ack stayed high for more than one cycle");
// Read data while ack is high
rd_data_ok: assert property (@(posedge clk_sys) disable iff (reset)
    (wb_ack && !wb_we) |-> wb_dat_r == exp_rd_data)
    else log_mismatch("wb_dat_r", 32'($sampled(wb_dat_r)), 32'($sampled(exp_rd_data)));
map_ok: assert property (@(posedge clk_sys) disable iff (reset)
    map_chk |-> ram_addr == exp_ram_addr)
    else log_mismatch("ram_addr", 32'($sampled(ram_addr)), 32'($sampled(exp_ram_addr)));
flags_ok: assert property (@(posedge clk_sys) disable iff (reset)
    {tc, motor, speaker_en} == exp_flags)
    else log_mismatch("{tc,motor,speaker_en}", 32'($sampled({tc, motor, speaker_en})),
        32'($sampled(exp_flags)));
nmi_ok: assert property (@(posedge clk_sys) disable iff (reset) nmi == exp_nmi)
    else log_mismatch("nmi", 32'($sampled(nmi)), 32'($sampled(exp_nmi)));
irq_ok: assert property (@(posedge clk_sys) disable iff (reset) irq == exp_irq)
    else log_mismatch("irq", 32'($sampled(irq)), 32'($sampled(exp_irq)));
// F7 is never written, so the reset value holds throughout
vidctl_ok: assert property (@(posedge clk_sys) disable iff (reset)
    {inverse, disable_vid} == 2'b11)
    else log_mismatch("{inverse,disable_vid}", 32'($sampled({inverse, disable_vid})), 32'd3);
roller_ok: assert property (@(posedge clk_sys) disable iff (reset)
    vid_chk |-> roller_ptr == exp_roller)
    else log_mismatch("roller_ptr", 32'($sampled(roller_ptr)), 32'($sampled(exp_roller)));
yscroll_ok: assert property (@(posedge clk_sys) disable iff (reset)
    vid_chk |-> yscroll == exp_yscroll)
    else log_mismatch("yscroll", 32'($sampled(yscroll)), 32'($sampled(exp_yscroll)));
pal_ok: assert property (@(posedge clk_sys) disable iff (reset) pal_chk |-> rgb == exp_rgb)
    else log_mismatch("rgb", 32'($sampled(rgb)), 32'($sampled(exp_rgb)));

/* test/tb_pcw_sysctl.sv */
`timescale 1ns/1ps

`include "pcw_cfg.svh"

module tb_pcw_sysctl;

    import pcw_pkg::*;

    // Stimulus needs about 350 cycles, the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk_sys;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic [15:0] mem_addr;
    logic        mem_rd;
    logic [17:0] ram_addr;
    logic        fdc_int;
    logic        vid_timer;
    logic        iff1;
    logic        vblank;
    logic        ntsc;
    logic        nmi;
    logic        irq;
    logic        tc;
    logic        motor;
    logic        speaker_en;
    logic [7:0]  roller_ptr;
    logic [7:0]  yscroll;
    logic        inverse;
    logic        disable_vid;
    logic [3:0]  rgbi;
    disp_color_e disp_color;
    logic [17:0] rgb;

    // Expected outputs and check enables
    logic [7:0]  exp_rd_data;
    logic [17:0] exp_ram_addr;
    logic [17:0] exp_rgb;
    logic [2:0]  exp_flags;
    logic        exp_nmi;
    logic        exp_irq;
    logic [7:0]  exp_roller;
    logic [7:0]  exp_yscroll;
    logic        map_chk;
    logic        pal_chk;
    logic        vid_chk;
    // Copies of the page map and the interrupt model state
    logic [7:0]  page_val [4];
    logic [7:0]  lock_val;
    logic        m_disk_nmi;
    logic        m_disk_int;
    logic        m_nmi_flag;
    logic        m_fdc_latch;
    logic        m_timer_line;
    logic        m_int_line;
    logic [3:0]  m_misses;
    integer      seed;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    pcw_sysctl uut (.*);

    always #5 clk_sys = ~clk_sys;

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("ERROR at %0t: %s = %0h, expected %0h", $time, name, got, expected);
        value_errors++;
    endtask

    task automatic log_failure(input string what);
        $display("FAILURE at %0t: %s", $time, what);
        other_errors++;
    endtask

    task automatic wait_for_ack;
        do
        begin
            @(posedge clk_sys);
            #1;
        end
        while (!wb_ack);
    endtask

    // we stays put after the cycle so the ack edge is still seen as a write
    task automatic write_port(input logic [7:0] adr, input logic [7:0] dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_for_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // Data is checked on the edge that ends the ack cycle
    task automatic read_port(input logic [7:0] adr);
        // A write still in its ack cycle finishes first
        while (wb_ack)
        begin
            @(posedge clk_sys);
            #1;
        end
        exp_rd_data = status_expected(adr);
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = 1'b0;
        wb_adr      = adr;
        wait_for_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge clk_sys);
        #1;
    endtask

    // Command in the low nibble, junk in the high one
    task automatic send_cmd(input logic [3:0] code);
        write_port(`PORT_SYSCTL, {4'($random(seed)), code});
        case (code)
            `CMD_DISK_NMI:
            begin
                m_disk_nmi = 1'b1;
                m_disk_int = 1'b0;
            end
            `CMD_DISK_INT:
            begin
                m_disk_nmi = 1'b0;
                m_disk_int = 1'b1;
            end
            `CMD_DISK_OFF:
            begin
                m_disk_nmi = 1'b0;
                m_disk_int = 1'b0;
            end
            `CMD_TC_SET:    exp_flags[2] = 1'b1;
            `CMD_TC_CLR:    exp_flags[2] = 1'b0;
            `CMD_MOTOR_ON:  exp_flags[1] = 1'b1;
            `CMD_MOTOR_OFF: exp_flags[1] = 1'b0;
            `CMD_SPK_ON:    exp_flags[0] = 1'b1;
            `CMD_SPK_OFF:   exp_flags[0] = 1'b0;
            default: ;
        endcase
        // Mode change pulse reaches the interrupt block a cycle later
        if (code == `CMD_DISK_INT || code == `CMD_DISK_OFF)
        begin
            @(posedge clk_sys);
            #1;
            m_nmi_flag = 1'b0;
            if (!m_disk_int)
                m_int_line = 1'b0;
            exp_irq = m_timer_line | m_int_line;
        end
    endtask

    // One vid_timer pulse, lines move two edges after the rise
    task automatic timer_tick;
        vid_timer = 1'b1;
        @(posedge clk_sys);
        #1;
        vid_timer = 1'b0;
        @(posedge clk_sys);
        #1;
        if (m_misses != 4'd15)
            m_misses = m_misses + 4'd1;
        m_timer_line = iff1;
        m_int_line   = m_disk_int && m_fdc_latch && iff1;
        exp_nmi      = m_nmi_flag;
        exp_irq      = m_timer_line | m_int_line;
    endtask

    task automatic fdc_edge(input logic level);
        fdc_int = level;
        repeat (2) @(posedge clk_sys);
        #1;
        if (level && m_disk_nmi)
            m_nmi_flag = 1'b1;
        m_fdc_latch = level;
    endtask

    // Random CPU addresses against the current page map
    task automatic map_sweep(input int count);
        for (int i = 0; i < count; i++)
        begin
            mem_addr     = 16'($random(seed));
            mem_rd       = 1'($random(seed));
            exp_ram_addr = map_expected(mem_addr, mem_rd);
            map_chk      = 1'b1;
            @(posedge clk_sys);
            #1;
        end
        map_chk = 1'b0;
    endtask

    task automatic end_run(input logic timed_out);
        int total_other;
        total_other = other_errors + (timed_out ? 1 : 0);
        $display("Errors: %0d mismatches, %0d other failures", value_errors, total_other);
        if (value_errors == 0 && total_other == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    `include "tb_pcw_props.svh"

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
        end_run(1'b1);
    end

    initial
    begin
        logic [7:0] val;
        seed         = 94961;
        clk_sys      = 1'b0;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 8'h00;
        wb_dat_w     = 8'h00;
        mem_addr     = 16'h0000;
        mem_rd       = 1'b0;
        fdc_int      = 1'b0;
        vid_timer    = 1'b0;
        iff1         = 1'b0;
        vblank       = 1'b1;
        ntsc         = 1'b0;
        rgbi         = 4'd0;
        disp_color   = DISP_WHITE;
        exp_rd_data  = 8'hFF;
        exp_ram_addr = 18'd0;
        exp_rgb      = 18'd0;
        exp_flags    = 3'b000;
        exp_nmi      = 1'b0;
        exp_irq      = 1'b0;
        exp_roller   = 8'h00;
        exp_yscroll  = 8'h00;
        map_chk      = 1'b0;
        pal_chk      = 1'b0;
        vid_chk      = 1'b0;
        lock_val     = 8'h00;
        m_disk_nmi   = 1'b0;
        m_disk_int   = 1'b0;
        m_nmi_flag   = 1'b0;
        m_fdc_latch  = 1'b0;
        m_timer_line = 1'b0;
        m_int_line   = 1'b0;
        m_misses     = 4'd0;
        value_errors = 0;
        other_errors = 0;
        repeat (4) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        // Video registers and read path
        val = 8'($random(seed));
        write_port(`PORT_ROLLER, val);
        exp_roller = val;
        vid_chk    = 1'b1;
        val = 8'($random(seed));
        write_port(`PORT_YSCROLL, val);
        exp_yscroll = val;
        read_port(`PORT_ROLLER);
        read_port(`PORT_SYSCTL);

        // PCW paging, mode bit set in every slot
        for (int i = 0; i < 4; i++)
        begin
            page_val[i] = {1'b1, 7'($random(seed))};
            write_port(8'(`PORT_PAGE0 + i), page_val[i]);
        end
        map_sweep(64);

        // CPC paging with random read locks
        for (int i = 0; i < 4; i++)
        begin
            page_val[i] = {1'b0, 7'($random(seed))};
            write_port(8'(`PORT_PAGE0 + i), page_val[i]);
        end
        lock_val = 8'($random(seed));
        write_port(`PORT_LOCK, lock_val);
        map_sweep(64);

        // Output flags, code 0 in between must leave them alone
        send_cmd(`CMD_MOTOR_ON);
        send_cmd(`CMD_TC_SET);
        send_cmd(`CMD_SPK_ON);
        send_cmd(4'd0);
        send_cmd(`CMD_MOTOR_OFF);
        send_cmd(`CMD_TC_CLR);
        send_cmd(`CMD_SPK_OFF);
        send_cmd(4'd0);

        // Timer misses saturate, irq tracks iff1
        repeat (4) timer_tick();
        iff1 = 1'b1;
        repeat (16) timer_tick();
        read_port(`PORT_SYSCTL);
        read_port(`PORT_LOCK);
        repeat (`TIMER_CLEAR_CYCLES) @(posedge clk_sys);
        #1;
        m_misses     = 4'd0;
        m_timer_line = 1'b0;
        exp_irq      = m_timer_line | m_int_line;
        read_port(`PORT_SYSCTL);

        // Disk interrupt routed to NMI, then disconnected
        send_cmd(`CMD_DISK_NMI);
        fdc_edge(1'b1);
        read_port(`PORT_SYSCTL);
        timer_tick();
        fdc_edge(1'b0);
        send_cmd(`CMD_DISK_OFF);
        timer_tick();
        read_port(`PORT_SYSCTL);

        // Every palette choice against every rgbi value
        pal_chk = 1'b1;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 16; r++)
            begin
                disp_color = disp_color_e'(c);
                rgbi       = 4'(r);
                exp_rgb    = palette_expected(disp_color, rgbi);
                @(posedge clk_sys);
                #1;
            end
        end
        pal_chk = 1'b0;
        end_run(1'b0);
    end

endmodule

/* hw/pcw_sysctl.sv */
`timescale 1ns/1ps

module pcw_sysctl (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [7:0]           wb_adr,
    input  logic [7:0]           wb_dat_w,
    output logic [7:0]           wb_dat_r,
    output logic                 wb_ack,
    input  logic [15:0]          mem_addr,
    input  logic                 mem_rd,
    output logic [17:0]          ram_addr,
    input  logic                 fdc_int,
    input  logic                 vid_timer,
    input  logic                 iff1,
    input  logic                 vblank,
    input  logic                 ntsc,
    output logic                 nmi,
    output logic                 irq,
    output logic                 tc,
    output logic                 motor,
    output logic                 speaker_en,
    output logic [7:0]           roller_ptr,
    output logic [7:0]           yscroll,
    output logic                 inverse,
    output logic                 disable_vid,
    input  logic [3:0]           rgbi,
    input  pcw_pkg::disp_color_e disp_color,
    output logic [17:0]          rgb
);

    import pcw_pkg::*;

    // Page map from the port block to the bank mapper
    page_reg_u  page0;
    page_reg_u  page1;
    page_reg_u  page2;
    page_reg_u  page3;
    logic [7:0] lock;
    // Disk routing and timer clear towards the interrupt block
    logic       disk_nmi;
    logic       disk_int;
    logic       mode_change_pulse;
    logic       clear_start;
    // Status bits back for F8
    logic       fdc_latch;
    logic [3:0] timer_misses;

    pcw_io_regs u_io_regs (
        .*
    );

    pcw_bank_map u_bank_map (
        .*
    );

    pcw_int_ctrl u_int_ctrl (
        .*
    );

    mono_palette u_palette (
        .*
    );

endmodule

/* hw/mono_palette.sv */
`timescale 1ns/1ps

`include "pcw_cfg.svh"

module mono_palette (
    input  logic [3:0]           rgbi,
    input  pcw_pkg::disp_color_e disp_color,
    output logic [17:0]          rgb
);

    import pcw_pkg::*;

    logic [17:0] norm_col;
    logic [17:0] bright_col;

    // Pick the colour pair for the chosen display
    always_comb
    begin
        case (disp_color)
            DISP_WHITE:
            begin
                norm_col   = `RGB_WHITE_NORM;
                bright_col = `RGB_WHITE_BRIGHT;
            end
            DISP_GREEN:
            begin
                norm_col   = `RGB_GREEN_NORM;
                bright_col = `RGB_GREEN_BRIGHT;
            end
            DISP_AMBER:
            begin
                norm_col   = `RGB_AMBER_NORM;
                bright_col = `RGB_AMBER_BRIGHT;
            end
            default:
            begin
                norm_col   = `RGB_WHITE_NORM;
                bright_col = `RGB_WHITE_NORM;
            end
        endcase
    end

    // Default choice is solid white, black included
    always_comb
    begin
        if (disp_color == DISP_DEFAULT)
            rgb = `RGB_WHITE_NORM;
        else if (rgbi == 4'b0000)
            rgb = 18'd0;
        else if (rgbi == 4'b1000)
            rgb = bright_col;
        else
            rgb = norm_col;
    end

endmodule

/* hw/pcw_int_ctrl.sv */
`timescale 1ns/1ps

`include "pcw_cfg.svh"

module pcw_int_ctrl (
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       fdc_int,
    input  logic       vid_timer,
    input  logic       iff1,
    input  logic       disk_nmi,
    input  logic       disk_int,
    input  logic       mode_change_pulse,
    input  logic       clear_start,
    output logic       fdc_latch,
    output logic [3:0] timer_misses,
    output logic       nmi,
    output logic       irq
);

    localparam logic [4:0] CLEAR_LAST = 5'(`TIMER_CLEAR_CYCLES - 1);

    // Sample and previous sample of each input
    logic [1:0] fdc_sr;
    logic [1:0] timer_sr;
    logic       fdc_pe;
    logic       fdc_ne;
    logic       timer_pe;
    logic       nmi_flag;
    logic       timer_line;
    logic       int_line;
    logic       clear_active;
    logic [4:0] clear_cnt;
    logic       clear_fire;

    assign fdc_pe   = fdc_sr[0] && !fdc_sr[1];
    assign fdc_ne   = !fdc_sr[0] && fdc_sr[1];
    assign timer_pe = timer_sr[0] && !timer_sr[1];

    // Last cycle of the clear delay
    assign clear_fire = clear_active && (clear_cnt == CLEAR_LAST);

    // Timer and disk INT share the one irq line
    assign irq = timer_line | int_line;

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            fdc_sr       <= 2'b00;
            timer_sr     <= 2'b00;
            fdc_latch    <= 1'b0;
            nmi_flag     <= 1'b0;
            timer_misses <= 4'd0;
            timer_line   <= 1'b0;
            int_line     <= 1'b0;
            nmi          <= 1'b0;
            clear_active <= 1'b0;
            clear_cnt    <= 5'd0;
        end
        else
        begin
            fdc_sr   <= {fdc_sr[0], fdc_int};
            timer_sr <= {timer_sr[0], vid_timer};

            // Status latch tracks the FDC interrupt
            if (fdc_pe)
            begin
                fdc_latch <= 1'b1;
                if (disk_nmi)
                    nmi_flag <= 1'b1;
            end
            else if (fdc_ne)
                fdc_latch <= 1'b0;

            // 300 Hz tick, lines only move here
            if (timer_pe)
            begin
                if (timer_misses != 4'd15)
                    timer_misses <= timer_misses + 4'd1;
                timer_line <= iff1;
                nmi        <= nmi_flag;
                int_line   <= disk_int && fdc_latch && iff1;
            end

            // Clear lands a fixed delay after the F4 read
            if (clear_active)
            begin
                if (clear_fire)
                begin
                    clear_active <= 1'b0;
                    timer_misses <= 4'd0;
                    timer_line   <= 1'b0;
                end
                else
                    clear_cnt <= clear_cnt + 5'd1;
            end
            // Another read starts the delay over
            if (clear_start)
            begin
                clear_active <= 1'b1;
                clear_cnt    <= 5'd0;
            end

            // Routing change drops whatever the old route left pending
            if (mode_change_pulse)
            begin
                if (disk_nmi)
                    int_line <= 1'b0;
                else if (disk_int)
                    nmi_flag <= 1'b0;
                else
                begin
                    nmi_flag <= 1'b0;
                    int_line <= 1'b0;
                end
            end
        end
    end

    // Count saturates, only the delayed clear brings it back to 0
    misses_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
        (!$past(reset) && $past(timer_misses) == 4'd15 && timer_misses == 4'd0)
            |-> $past(clear_fire));

endmodule

/* hw/pcw_bank_map.sv */
`timescale 1ns/1ps

module pcw_bank_map (
    input  logic [15:0]        mem_addr,
    input  logic               mem_rd,
    input  pcw_pkg::page_reg_u page0,
    input  pcw_pkg::page_reg_u page1,
    input  pcw_pkg::page_reg_u page2,
    input  pcw_pkg::page_reg_u page3,
    input  logic [7:0]         lock,
    output logic [17:0]        ram_addr
);

    import pcw_pkg::*;

    // Register of the 16K slot being addressed
    page_reg_u   page_sel;
    logic [1:0]  slot;
    logic [13:0] offset;
    // CPC read lock for this slot
    logic        lock_bit;
    logic [2:0]  cpc_block;

    assign slot   = mem_addr[15:14];
    assign offset = mem_addr[13:0];

    always_comb
    begin
        case (slot)
            2'd0:    page_sel = page0;
            2'd1:    page_sel = page1;
            2'd2:    page_sel = page2;
            default: page_sel = page3;
        endcase
    end

    // Lock bits sit in F4 bits 7:4, one per slot
    assign lock_bit = lock[{1'b1, slot}];

    // Unlocked reads use the read block, all else the write block
    always_comb
    begin
        if (mem_rd && !lock_bit)
            cpc_block = page_sel.cpc.rd_block;
        else
            cpc_block = page_sel.cpc.wr_block;
    end

    // PCW mode reaches 256K, CPC mode only the lower 128K
    always_comb
    begin
        if (page_sel.pcw.mode)
            ram_addr = {page_sel.pcw.block[3:0], offset};
        else
            ram_addr = {1'b0, cpc_block, offset};
    end

endmodule

/* hw/pcw_io_regs.sv */
`timescale 1ns/1ps

`include "pcw_cfg.svh"

module pcw_io_regs (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [7:0]         wb_adr,
    input  logic [7:0]         wb_dat_w,
    output logic [7:0]         wb_dat_r,
    output logic               wb_ack,
    input  logic               vblank,
    input  logic               ntsc,
    input  logic               fdc_latch,
    input  logic [3:0]         timer_misses,
    output pcw_pkg::page_reg_u page0,
    output pcw_pkg::page_reg_u page1,
    output pcw_pkg::page_reg_u page2,
    output pcw_pkg::page_reg_u page3,
    output logic [7:0]         lock,
    output logic [7:0]         roller_ptr,
    output logic [7:0]         yscroll,
    output logic               inverse,
    output logic               disable_vid,
    output logic               tc,
    output logic               motor,
    output logic               speaker_en,
    output logic               disk_nmi,
    output logic               disk_int,
    output logic               mode_change_pulse,
    output logic               clear_start
);

    // New cycle seen, ack not yet given
    logic       wb_req;
    logic       wr_req;
    logic       rd_req;
    logic [7:0] vidctl;
    logic [7:0] status_byte;

    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = wb_req && wb_we;
    assign rd_req = wb_req && !wb_we;

    // Vblank, FDC latch, 50 Hz flag, timer misses
    assign status_byte = {1'b0, vblank, fdc_latch, ~ntsc, timer_misses};

    // Bit 7 inverse, bit 6 low blanks the screen
    assign inverse     = vidctl[7];
    assign disable_vid = ~vidctl[6];

    // Single wait state, ack for one cycle
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            wb_ack      <= 1'b0;
            clear_start <= 1'b0;
        end
        else
        begin
            wb_ack      <= wb_req;
            // F4 read restarts the timer clear delay
            clear_start <= rd_req && (wb_adr == `PORT_LOCK);
        end
    end

    // Only F4 and F8 answer, the rest float high
    always_ff @(posedge clk_sys)
    begin
        if (rd_req)
        begin
            if (wb_adr == `PORT_LOCK || wb_adr == `PORT_SYSCTL)
                wb_dat_r <= status_byte;
            else
                wb_dat_r <= 8'hFF;
        end
    end

    // Port registers and system control commands
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            page0             <= '0;
            page1             <= '0;
            page2             <= '0;
            page3             <= '0;
            lock              <= 8'h00;
            roller_ptr        <= 8'h00;
            yscroll           <= 8'h00;
            vidctl            <= `VIDCTL_RESET;
            tc                <= 1'b0;
            motor             <= 1'b0;
            speaker_en        <= 1'b0;
            disk_nmi          <= 1'b0;
            disk_int          <= 1'b0;
            mode_change_pulse <= 1'b0;
        end
        else
        begin
            mode_change_pulse <= 1'b0;
            if (wr_req)
            begin
                case (wb_adr)
                    `PORT_PAGE0:   page0      <= wb_dat_w;
                    `PORT_PAGE1:   page1      <= wb_dat_w;
                    `PORT_PAGE2:   page2      <= wb_dat_w;
                    `PORT_PAGE3:   page3      <= wb_dat_w;
                    `PORT_LOCK:    lock       <= wb_dat_w;
                    `PORT_ROLLER:  roller_ptr <= wb_dat_w;
                    `PORT_YSCROLL: yscroll    <= wb_dat_w;
                    `PORT_VIDCTL:  vidctl     <= wb_dat_w;
                    `PORT_SYSCTL:
                    begin
                        // Upper nibble is ignored
                        case (wb_dat_w[3:0])
                            `CMD_DISK_NMI:
                            begin
                                disk_nmi <= 1'b1;
                                disk_int <= 1'b0;
                            end
                            `CMD_DISK_INT:
                            begin
                                disk_nmi          <= 1'b0;
                                disk_int          <= 1'b1;
                                mode_change_pulse <= 1'b1;
                            end
                            `CMD_DISK_OFF:
                            begin
                                disk_nmi          <= 1'b0;
                                disk_int          <= 1'b0;
                                mode_change_pulse <= 1'b1;
                            end
                            `CMD_TC_SET:    tc         <= 1'b1;
                            `CMD_TC_CLR:    tc         <= 1'b0;
                            `CMD_MOTOR_ON:  motor      <= 1'b1;
                            `CMD_MOTOR_OFF: motor      <= 1'b0;
                            `CMD_SPK_ON:    speaker_en <= 1'b1;
                            `CMD_SPK_OFF:   speaker_en <= 1'b0;
                            // Bootstrap end, reset and spare codes
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // Master only strobes inside a bus cycle
    stb_in_cycle: assert property (@(posedge clk_sys) disable iff (reset)
        wb_stb |-> wb_cyc);

endmodule

/* hw/pcw_pkg.sv */
package pcw_pkg;

    // Page register, read as PCW or CPC layout depending on bit 7
    typedef union packed
    {
        // PCW layout, 16K block number in the low bits
        struct packed
        {
            logic       mode;
            logic [6:0] block;
        } pcw;
        // CPC layout, separate read and write blocks
        struct packed
        {
            logic       mode;
            logic [2:0] rd_block;
            logic       spare;
            logic [2:0] wr_block;
        } cpc;
    } page_reg_u;

    // Display colour chosen by the user
    typedef enum logic [1:0]
    {
        DISP_WHITE   = 2'd0,
        DISP_GREEN   = 2'd1,
        DISP_AMBER   = 2'd2,
        // Unused code, falls back to plain white
        DISP_DEFAULT = 2'd3
    } disp_color_e;

endpackage

/* hw/pcw_cfg.svh */
`ifndef PCW_CFG_SVH
`define PCW_CFG_SVH

// Page map ports, one 16K slot each
`define PORT_PAGE0      8'hF0
`define PORT_PAGE1      8'hF1
`define PORT_PAGE2      8'hF2
`define PORT_PAGE3      8'hF3
// CPC read lock on write, timer clear on read
`define PORT_LOCK       8'hF4
// Video control ports
`define PORT_ROLLER     8'hF5
`define PORT_YSCROLL    8'hF6
`define PORT_VIDCTL     8'hF7
// System control commands in, status out
`define PORT_SYSCTL     8'hF8

// Low nibble command codes written to F8
`define CMD_DISK_NMI    4'd2
`define CMD_DISK_INT    4'd3
`define CMD_DISK_OFF    4'd4
`define CMD_TC_SET      4'd5
`define CMD_TC_CLR      4'd6
`define CMD_MOTOR_ON    4'd9
`define CMD_MOTOR_OFF   4'd10
`define CMD_SPK_ON      4'd11
`define CMD_SPK_OFF     4'd12

// Inverse set and video off out of reset
`define VIDCTL_RESET    8'h80
// Cycles from an F4 read to the timer clear
`define TIMER_CLEAR_CYCLES 32

// Monochrome colours, 6 bits per channel
`define RGB_WHITE_NORM   18'b111110111110111110
`define RGB_WHITE_BRIGHT 18'b110111111111111111
`define RGB_GREEN_NORM   18'b000000111110000000
`define RGB_GREEN_BRIGHT 18'b011001111111011001
`define RGB_AMBER_NORM   18'b000000011111111110
`define RGB_AMBER_BRIGHT 18'b000000101100111111

`endif
